/* rtl/stamofu_pkg.sv */
// --------------------------------------------------------------------------
// Shared widths, queue sizing and the operation field encoding for the
// store/AMO/fence request path. Imported by the RTL and the testbench.
// --------------------------------------------------------------------------

package stamofu_pkg;

	// ----------------------------------------------------------------------
	// Address widths

	// Virtual page number, passed through untranslated
	localparam int VPN_WIDTH = 20;
	// Page offset; the word part drops the low two bits
	localparam int PO_WIDTH = 12;

	// ----------------------------------------------------------------------
	// Queue sizing

	localparam int LQ_ENTRIES = 4;
	localparam int LOG_LQ_ENTRIES = 2;

	// Completion queue index is only carried along
	localparam int LOG_CQ_ENTRIES = 3;

	// ----------------------------------------------------------------------
	// Operation field

	// Store view of the op field
	// Size 0 is a byte, 1 a half, 2 a word
	typedef struct packed {
		logic [1:0] rsvd;
		logic [1:0] size;
	} stamofu_store_op_t;

	// Same 4 bits, read as a store size or as an AMO function.
	// AMOs are always word sized, so the AMO view needs no size.
	typedef union packed {
		stamofu_store_op_t store;
		logic [3:0] amo_funct;
	} stamofu_op_u;

endpackage

/* rtl/stamofu_req_former.sv */
// --------------------------------------------------------------------------
// Request former. Registers one dispatched store, AMO or fence and works out
// its byte mask, lane-aligned write data and misalignment status.
// --------------------------------------------------------------------------

`timescale 1ns/1ns

module stamofu_req_former import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// Dispatch side
	input logic in_valid,
	input logic in_is_store,
	input logic in_is_amo,
	input logic in_is_fence,
	input stamofu_op_u in_op,
	input logic [VPN_WIDTH-1:0] in_vpn,
	input logic [PO_WIDTH-1:0] in_po,
	input logic [31:0] in_write_data,
	input logic [LOG_CQ_ENTRIES-1:0] in_cq_index,
	output logic in_ack,

	// Launch queue enqueue side
	output logic enq_valid,
	output logic enq_is_store,
	output logic enq_is_amo,
	output logic enq_is_fence,
	output stamofu_op_u enq_op,
	output logic enq_is_mq,
	output logic enq_misaligned,
	output logic enq_misaligned_exception,
	output logic [VPN_WIDTH-1:0] enq_vpn,
	output logic [PO_WIDTH-3:0] enq_po_word,
	output logic [3:0] enq_byte_mask,
	output logic [31:0] enq_write_data,
	output logic [LOG_CQ_ENTRIES-1:0] enq_cq_index,
	input logic enq_ack
);

	logic take;
	logic [1:0] size;
	logic [1:0] offset;
	logic [2:0] access_bytes;
	logic [3:0] base_mask;
	logic [7:0] wide_mask;
	logic misaligned;

	// Stage is free when empty or when its request leaves this cycle
	assign in_ack = ~enq_valid | enq_ack;
	assign take = in_valid & in_ack;

	// ----------------------------------------------------------------------
	// Size, mask and misalignment

	always_comb begin
		// AMOs are word sized regardless of the op bits
		size = in_is_amo ? 2'd2 : in_op.store.size;
		offset = in_po[1:0];
		case (size)
			2'd0: begin
				access_bytes = 3'd1;
				base_mask = 4'h1;
			end
			2'd1: begin
				access_bytes = 3'd2;
				base_mask = 4'h3;
			end
			default: begin
				access_bytes = 3'd4;
				base_mask = 4'hF;
			end
		endcase
		// Bytes past lane 3 fall off here and go to the MQ half
		wide_mask = {4'h0, base_mask} << offset;
		misaligned = ({1'b0, offset} + access_bytes) > 3'd4;
	end

	// ----------------------------------------------------------------------
	// Stage registers

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			enq_valid <= 1'b0;
		end
		else if (take) begin
			enq_valid <= 1'b1;
		end
		else if (enq_ack) begin
			enq_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			enq_is_store <= in_is_store;
			enq_is_amo <= in_is_amo;
			enq_is_fence <= in_is_fence;
			enq_op <= in_op;
			enq_vpn <= in_vpn;
			enq_po_word <= in_po[PO_WIDTH-1:2];
			enq_cq_index <= in_cq_index;
			// Fences carry no data and never split
			enq_byte_mask <= in_is_fence ? 4'h0 : wide_mask[3:0];
			enq_write_data <= in_is_fence ? 32'h0 : in_write_data << {offset, 3'b000};
			enq_misaligned <= ~in_is_fence & misaligned;
			enq_is_mq <= in_is_store & ~in_is_fence & misaligned;
			enq_misaligned_exception <= in_is_amo & ~in_is_fence & misaligned;
		end
	end

endmodule

/* rtl/stamofu_lq.sv */
// --------------------------------------------------------------------------
// Launch queue. Four-entry circular FIFO between the request former and the
// launcher, with valid/ack on both enqueue and dequeue.
// --------------------------------------------------------------------------

`timescale 1ns/1ns

module stamofu_lq import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// Enqueue from the former
	input logic enq_valid,
	input logic enq_is_store,
	input logic enq_is_amo,
	input logic enq_is_fence,
	input stamofu_op_u enq_op,
	input logic enq_is_mq,
	input logic enq_misaligned,
	input logic enq_misaligned_exception,
	input logic [VPN_WIDTH-1:0] enq_vpn,
	input logic [PO_WIDTH-3:0] enq_po_word,
	input logic [3:0] enq_byte_mask,
	input logic [31:0] enq_write_data,
	input logic [LOG_CQ_ENTRIES-1:0] enq_cq_index,
	output logic enq_ack,

	// Dequeue to the launcher
	output logic deq_valid,
	output logic deq_is_store,
	output logic deq_is_amo,
	output logic deq_is_fence,
	output stamofu_op_u deq_op,
	output logic deq_is_mq,
	output logic deq_misaligned,
	output logic deq_misaligned_exception,
	output logic [VPN_WIDTH-1:0] deq_vpn,
	output logic [PO_WIDTH-3:0] deq_po_word,
	output logic [3:0] deq_byte_mask,
	output logic [31:0] deq_write_data,
	output logic [LOG_CQ_ENTRIES-1:0] deq_cq_index,
	input logic deq_ack
);

	// Entry storage
	logic is_store_q [LQ_ENTRIES];
	logic is_amo_q [LQ_ENTRIES];
	logic is_fence_q [LQ_ENTRIES];
	stamofu_op_u op_q [LQ_ENTRIES];
	logic is_mq_q [LQ_ENTRIES];
	logic misaligned_q [LQ_ENTRIES];
	logic misaligned_exception_q [LQ_ENTRIES];
	logic [VPN_WIDTH-1:0] vpn_q [LQ_ENTRIES];
	logic [PO_WIDTH-3:0] po_word_q [LQ_ENTRIES];
	logic [3:0] byte_mask_q [LQ_ENTRIES];
	logic [31:0] write_data_q [LQ_ENTRIES];
	logic [LOG_CQ_ENTRIES-1:0] cq_index_q [LQ_ENTRIES];

	logic [LOG_LQ_ENTRIES-1:0] head;
	logic [LOG_LQ_ENTRIES-1:0] tail;
	logic [LOG_LQ_ENTRIES:0] count;
	logic do_enq;
	logic do_deq;

	// Count MSB is set only at LQ_ENTRIES
	assign enq_ack = ~count[LOG_LQ_ENTRIES];
	assign deq_valid = count != '0;
	assign do_enq = enq_valid & enq_ack;
	assign do_deq = deq_valid & deq_ack;

	// ----------------------------------------------------------------------
	// Pointers and occupancy

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else begin
			// Pointers wrap naturally at the power-of-two depth
			if (do_enq)
				tail <= tail + 1'b1;
			if (do_deq)
				head <= head + 1'b1;
			if (do_enq & ~do_deq)
				count <= count + 1'b1;
			else if (do_deq & ~do_enq)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (do_enq) begin
			is_store_q[tail] <= enq_is_store;
			is_amo_q[tail] <= enq_is_amo;
			is_fence_q[tail] <= enq_is_fence;
			op_q[tail] <= enq_op;
			is_mq_q[tail] <= enq_is_mq;
			misaligned_q[tail] <= enq_misaligned;
			misaligned_exception_q[tail] <= enq_misaligned_exception;
			vpn_q[tail] <= enq_vpn;
			po_word_q[tail] <= enq_po_word;
			byte_mask_q[tail] <= enq_byte_mask;
			write_data_q[tail] <= enq_write_data;
			cq_index_q[tail] <= enq_cq_index;
		end
	end

	// Oldest entry is always presented
	assign deq_is_store = is_store_q[head];
	assign deq_is_amo = is_amo_q[head];
	assign deq_is_fence = is_fence_q[head];
	assign deq_op = op_q[head];
	assign deq_is_mq = is_mq_q[head];
	assign deq_misaligned = misaligned_q[head];
	assign deq_misaligned_exception = misaligned_exception_q[head];
	assign deq_vpn = vpn_q[head];
	assign deq_po_word = po_word_q[head];
	assign deq_byte_mask = byte_mask_q[head];
	assign deq_write_data = write_data_q[head];
	assign deq_cq_index = cq_index_q[head];

endmodule

/* rtl/stamofu_launcher.sv */
// --------------------------------------------------------------------------
// Launcher. Pops the launch queue and turns each entry into a held data
// cache request, or into a one-cycle exception report for misaligned AMOs.
// --------------------------------------------------------------------------

`timescale 1ns/1ns

module stamofu_launcher import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// Launch queue dequeue side
	input logic deq_valid,
	input logic deq_is_store,
	input logic deq_is_amo,
	input logic deq_is_fence,
	input stamofu_op_u deq_op,
	input logic deq_is_mq,
	input logic deq_misaligned,
	input logic deq_misaligned_exception,
	input logic [VPN_WIDTH-1:0] deq_vpn,
	input logic [PO_WIDTH-3:0] deq_po_word,
	input logic [3:0] deq_byte_mask,
	input logic [31:0] deq_write_data,
	input logic [LOG_CQ_ENTRIES-1:0] deq_cq_index,
	output logic deq_ack,

	// Data cache request
	output logic dc_req_valid,
	output logic dc_req_is_fence,
	output logic dc_req_is_amo,
	output logic [3:0] dc_req_amo_funct,
	output logic dc_req_is_mq,
	output logic [VPN_WIDTH-1:0] dc_req_vpn,
	output logic [PO_WIDTH-3:0] dc_req_po_word,
	output logic [3:0] dc_req_byte_mask,
	output logic [31:0] dc_req_write_data,
	output logic [LOG_CQ_ENTRIES-1:0] dc_req_cq_index,
	input logic dc_req_ack,

	// Exception report
	output logic exc_valid,
	output logic [LOG_CQ_ENTRIES-1:0] exc_cq_index
);

	logic take;
	logic take_req;
	logic take_exc;

	// Pop only when the request register is free this cycle.
	// Exceptions also wait here so they stay in order with requests.
	assign deq_ack = ~dc_req_valid | dc_req_ack;
	assign take = deq_valid & deq_ack;
	assign take_exc = take & deq_misaligned_exception;
	assign take_req = take & ~deq_misaligned_exception;

	// ----------------------------------------------------------------------
	// Control

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			dc_req_valid <= 1'b0;
			exc_valid <= 1'b0;
		end
		else begin
			exc_valid <= take_exc;
			if (take)
				dc_req_valid <= take_req;
			else if (dc_req_ack)
				dc_req_valid <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// Payload, held until the cache acks

	always_ff @(posedge CLK) begin
		if (take_req) begin
			dc_req_is_fence <= deq_is_fence;
			dc_req_is_amo <= deq_is_amo;
			// Function bits only mean something for an AMO
			dc_req_amo_funct <= deq_is_amo ? deq_op.amo_funct : 4'h0;
			// Split only applies to a misaligned store
			dc_req_is_mq <= deq_is_mq & deq_is_store & deq_misaligned;
			dc_req_vpn <= deq_vpn;
			dc_req_po_word <= deq_po_word;
			dc_req_byte_mask <= deq_byte_mask;
			dc_req_write_data <= deq_write_data;
			dc_req_cq_index <= deq_cq_index;
		end
		if (take_exc) begin
			exc_cq_index <= deq_cq_index;
		end
	end

endmodule

/* rtl/stamofu_launch_top.sv */
// --------------------------------------------------------------------------
// Request path top level. Chains the request former, the launch queue and
// the launcher; dispatch goes in, cache requests and exceptions come out.
// --------------------------------------------------------------------------

`timescale 1ns/1ns

module stamofu_launch_top import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// Dispatch
	input logic in_valid,
	input logic in_is_store,
	input logic in_is_amo,
	input logic in_is_fence,
	input stamofu_op_u in_op,
	input logic [VPN_WIDTH-1:0] in_vpn,
	input logic [PO_WIDTH-1:0] in_po,
	input logic [31:0] in_write_data,
	input logic [LOG_CQ_ENTRIES-1:0] in_cq_index,
	output logic in_ack,

	// Data cache request
	output logic dc_req_valid,
	output logic dc_req_is_fence,
	output logic dc_req_is_amo,
	output logic [3:0] dc_req_amo_funct,
	output logic dc_req_is_mq,
	output logic [VPN_WIDTH-1:0] dc_req_vpn,
	output logic [PO_WIDTH-3:0] dc_req_po_word,
	output logic [3:0] dc_req_byte_mask,
	output logic [31:0] dc_req_write_data,
	output logic [LOG_CQ_ENTRIES-1:0] dc_req_cq_index,
	input logic dc_req_ack,

	// Exception report
	output logic exc_valid,
	output logic [LOG_CQ_ENTRIES-1:0] exc_cq_index
);

	// ----------------------------------------------------------------------
	// Former to queue
	logic enq_valid;
	logic enq_is_store;
	logic enq_is_amo;
	logic enq_is_fence;
	stamofu_op_u enq_op;
	logic enq_is_mq;
	logic enq_misaligned;
	logic enq_misaligned_exception;
	logic [VPN_WIDTH-1:0] enq_vpn;
	logic [PO_WIDTH-3:0] enq_po_word;
	logic [3:0] enq_byte_mask;
	logic [31:0] enq_write_data;
	logic [LOG_CQ_ENTRIES-1:0] enq_cq_index;
	logic enq_ack;

	// ----------------------------------------------------------------------
	// Queue to launcher
	logic deq_valid;
	logic deq_is_store;
	logic deq_is_amo;
	logic deq_is_fence;
	stamofu_op_u deq_op;
	logic deq_is_mq;
	logic deq_misaligned;
	logic deq_misaligned_exception;
	logic [VPN_WIDTH-1:0] deq_vpn;
	logic [PO_WIDTH-3:0] deq_po_word;
	logic [3:0] deq_byte_mask;
	logic [31:0] deq_write_data;
	logic [LOG_CQ_ENTRIES-1:0] deq_cq_index;
	logic deq_ack;

	// Port names match the wires above one for one
	stamofu_req_former req_former (.*);

	stamofu_lq lq (.*);

	stamofu_launcher launcher (.*);

endmodule

/* bench/stamofu_assertions.sv */
// --------------------------------------------------------------------------
// Handshake checks for the launch queue, bound into every stamofu_lq.
// Occupancy is rebuilt here from the enqueue and dequeue handshakes.
// --------------------------------------------------------------------------

`timescale 1ns/1ns

module stamofu_assertions import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic enq_valid,
	input logic enq_ack,
	input logic deq_valid,
	input logic deq_ack
);

	logic [LOG_LQ_ENTRIES:0] occupancy;
	logic push;
	logic pop;
	int failures = 0;

	assign push = enq_valid & enq_ack;
	assign pop = deq_valid & deq_ack;

	// Reference occupancy seen from the two handshakes
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST)
			occupancy <= '0;
		else
			occupancy <= occupancy + {{LOG_LQ_ENTRIES{1'b0}}, push}
				- {{LOG_LQ_ENTRIES{1'b0}}, pop};
	end

	// Nothing to pop while empty
	empty_no_deq: assert property (@(posedge CLK) disable iff (~nRST)
		occupancy == '0 |-> ~deq_valid)
		else begin
			$error("deq_valid high while the launch queue is empty");
			failures++;
		end

	// No room while full
	full_no_enq: assert property (@(posedge CLK) disable iff (~nRST)
		occupancy == LQ_ENTRIES |-> ~enq_ack)
		else begin
			$error("enq_ack high while the launch queue is full");
			failures++;
		end

	// First cycle out of reset
	idle_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> ~deq_valid)
		else begin
			$error("deq_valid high in the cycle after reset release");
			failures++;
		end

endmodule

bind stamofu_lq stamofu_assertions lq_checks (.*);

/* bench/stamofu_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the store/AMO/fence request path. Reads requests and expected
// results from the data file, drives them back to back under random cache
// back-pressure and checks every cache request or exception in order.
// --------------------------------------------------------------------------

`timescale 1ns/1ns

module stamofu_tb import stamofu_pkg::*; ();

	logic CLK;
	logic nRST;
	logic in_valid;
	logic in_is_store;
	logic in_is_amo;
	logic in_is_fence;
	stamofu_op_u in_op;
	logic [VPN_WIDTH-1:0] in_vpn;
	logic [PO_WIDTH-1:0] in_po;
	logic [31:0] in_write_data;
	logic [LOG_CQ_ENTRIES-1:0] in_cq_index;
	logic in_ack;
	logic dc_req_valid;
	logic dc_req_is_fence;
	logic dc_req_is_amo;
	logic [3:0] dc_req_amo_funct;
	logic dc_req_is_mq;
	logic [VPN_WIDTH-1:0] dc_req_vpn;
	logic [PO_WIDTH-3:0] dc_req_po_word;
	logic [3:0] dc_req_byte_mask;
	logic [31:0] dc_req_write_data;
	logic [LOG_CQ_ENTRIES-1:0] dc_req_cq_index;
	logic dc_req_ack;
	logic exc_valid;
	logic [LOG_CQ_ENTRIES-1:0] exc_cq_index;

	// One row per request, columns as in the data file header
	logic [31:0] vec [64][14];
	int n_tests;
	int cur_idx;
	int pending [$];
	int checked;
	int passes;
	int fails;
	int other_errors;
	bit held;
	logic [75:0] dc_fields;
	logic [75:0] held_fields;
	logic [31:0] lfsr;

	stamofu_launch_top dut (.*);

	// Everything the cache sees, for the hold check
	assign dc_fields = {dc_req_is_fence, dc_req_is_amo, dc_req_amo_funct, dc_req_is_mq,
		dc_req_vpn, dc_req_po_word, dc_req_byte_mask, dc_req_write_data, dc_req_cq_index};

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic load_vectors();
		int fd;
		string line;
		fd = $fopen("bench/stamofu_input.txt", "r");
		n_tests = 0;
		if (fd != 0) begin
			while (!$feof(fd)) begin
				// Comment and blank lines fail the scan
				if ($fgets(line, fd) != 0 && $sscanf(line,
					"%d %h %h %h %h %h %h %h %h %h %h %h %h %h",
					vec[n_tests][0], vec[n_tests][1], vec[n_tests][2], vec[n_tests][3],
					vec[n_tests][4], vec[n_tests][5], vec[n_tests][6], vec[n_tests][7],
					vec[n_tests][8], vec[n_tests][9], vec[n_tests][10], vec[n_tests][11],
					vec[n_tests][12], vec[n_tests][13]) == 14)
					n_tests++;
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_request(input int i);
		cur_idx = i;
		in_valid = 1'b1;
		in_is_store = vec[i][1][0];
		in_is_amo = vec[i][2][0];
		in_is_fence = vec[i][3][0];
		in_op = vec[i][4][3:0];
		in_vpn = vec[i][5][VPN_WIDTH-1:0];
		in_po = vec[i][6][PO_WIDTH-1:0];
		in_write_data = vec[i][7];
		in_cq_index = vec[i][8][LOG_CQ_ENTRIES-1:0];
	endtask

	task automatic compare_hex(input int id, input string name, input logic [31:0] exp,
		input logic [31:0] act, inout bit ok);
		assert (exp === act) else begin
			$display("[FAIL] test %0d %s expected %h got %h", id, name, exp, act);
			ok = 0;
		end
	endtask

	task automatic check_output(input bit is_exc);
		int t;
		int id;
		bit ok;
		assert (pending.size() > 0) else begin
			$display("An output came out with no request outstanding");
			other_errors++;
		end
		if (pending.size() > 0) begin
			t = pending.pop_front();
			id = vec[t][0];
			ok = 1;
			assert (vec[t][9][0] == is_exc) else begin
				$display("Test %0d came out as the wrong kind of output", id);
				ok = 0;
			end
			if (ok && is_exc) begin
				compare_hex(id, "exc_cq_index", vec[t][8], exc_cq_index, ok);
			end
			else if (ok) begin
				compare_hex(id, "dc_req_byte_mask", vec[t][10], dc_req_byte_mask, ok);
				compare_hex(id, "dc_req_write_data", vec[t][11], dc_req_write_data, ok);
				compare_hex(id, "dc_req_is_mq", vec[t][12], dc_req_is_mq, ok);
				compare_hex(id, "dc_req_amo_funct", vec[t][13], dc_req_amo_funct, ok);
				compare_hex(id, "dc_req_is_fence", vec[t][3], dc_req_is_fence, ok);
				compare_hex(id, "dc_req_is_amo", vec[t][2], dc_req_is_amo, ok);
				compare_hex(id, "dc_req_vpn", vec[t][5], dc_req_vpn, ok);
				compare_hex(id, "dc_req_po_word", vec[t][6] >> 2, dc_req_po_word, ok);
				compare_hex(id, "dc_req_cq_index", vec[t][8], dc_req_cq_index, ok);
			end
			if (ok) begin
				passes++;
				$display("test %0d ok", id);
			end
			else begin
				fails++;
				$display("test %0d wrong", id);
			end
			checked++;
		end
	endtask

	// Random cache back-pressure, acked about one cycle in four
	initial begin : backpressure
		bit b0;
		bit b1;
		lfsr = 32'd74584;
		dc_req_ack = 1'b0;
		@(posedge nRST);
		forever begin
			@(posedge CLK);
			#10;
			lfsr = lfsr_next(lfsr);
			b0 = lfsr[0];
			lfsr = lfsr_next(lfsr);
			b1 = lfsr[0];
			dc_req_ack = b0 & b1;
		end
	end

	// ----------------------------------------------------------------------
	// Monitor, sampled mid-cycle where every handshake is settled

	always @(negedge CLK) begin
		if (nRST) begin
			if (in_valid && in_ack)
				pending.push_back(cur_idx);
			if (held) begin
				assert (dc_req_valid && dc_fields == held_fields) else begin
					$display("The cache request changed or dropped before its ack");
					other_errors++;
				end
			end
			held = dc_req_valid && !dc_req_ack;
			held_fields = dc_fields;
			if (exc_valid)
				check_output(1'b1);
			if (dc_req_valid && dc_req_ack)
				check_output(1'b0);
		end
	end

	initial begin : watchdog
		wait (n_tests > 0);
		#((n_tests * 40 + 16) * 100);
		$display("Timed out after %0d cycles with requests still in flight",
			n_tests * 40 + 16);
		$display("Testbench failed");
		$finish;
	end

	initial begin : main
		nRST = 1'b0;
		in_valid = 1'b0;
		in_is_store = 1'b0;
		in_is_amo = 1'b0;
		in_is_fence = 1'b0;
		in_op = '0;
		in_vpn = '0;
		in_po = '0;
		in_write_data = '0;
		in_cq_index = '0;
		load_vectors();
		repeat (16) @(posedge CLK);
		#10;
		nRST = 1'b1;
		if (n_tests == 0) begin
			$display("No stimulus lines could be read from the data file");
			$display("Testbench failed");
			$finish;
		end
		else begin
			for (int i = 0; i < n_tests; i++) begin
				drive_request(i);
				// Held until the former takes it
				do
					@(negedge CLK);
				while (!in_ack);
				@(posedge CLK);
				#10;
			end
			in_valid = 1'b0;
			wait (checked == n_tests);
			// A few idle cycles so a stray output gets noticed
			repeat (4) @(negedge CLK);
			// Launch queue handshake assertion failures
			other_errors += dut.lq.lq_checks.failures;
			$display("%0d tests passed, %0d tests failed, %0d other errors",
				passes, fails, other_errors);
			if (fails == 0 && other_errors == 0)
				$display("Testbench passed");
			else
				$display("Testbench failed");
			$finish;
		end
	end

endmodule

/* bench/stamofu_input.txt */
# test store amo fence op vpn po wdata cq | kind(0 req, 1 exc) mask wdata is_mq funct
# test number is decimal, every other column is hex
1  1 0 0 0 12345 104 000000a5 0  0 1 000000a5 0 0
2  1 0 0 0 0abcd 2a7 0000005c 1  0 8 5c000000 0 0
3  1 0 0 1 fffff 3f6 0000beef 2  0 c beef0000 0 0
4  1 0 0 2 00001 010 12345678 3  0 f 12345678 0 0
5  1 0 0 1 54321 0ff 0000cafe 4  0 8 fe000000 1 0
6  1 0 0 2 3c3c3 121 deadbeef 5  0 e adbeef00 1 0
7  0 1 0 b 77777 208 00000007 6  0 f 00000007 0 b
8  0 1 0 3 80000 20a 00000009 7  1 0 00000000 0 0
9  0 0 1 0 00000 000 ffffffff 0  0 0 00000000 0 0
10 1 0 0 0 1f00f 005 000000ff 1  0 2 0000ff00 0 0
11 1 0 0 1 2468a 7f8 aaaa1234 2  0 3 aaaa1234 0 0
12 0 1 0 6 13579 400 00000055 3  0 f 00000055 0 6
13 1 0 0 2 edcba 812 89abcdef 4  0 c cdef0000 1 0
14 0 1 0 1 0f0f0 00f 00000011 5  1 0 00000000 0 0
15 1 0 0 0 99999 ffe 00000033 6  0 4 00330000 0 0
16 0 0 1 0 00abc 555 00000001 7  0 0 00000000 0 0

/* project.f */
rtl/stamofu_pkg.sv
rtl/stamofu_req_former.sv
rtl/stamofu_lq.sv
rtl/stamofu_launcher.sv
rtl/stamofu_launch_top.sv
bench/stamofu_assertions.sv
bench/stamofu_tb.sv
